//--- Makefile
# Verilator flow for the PMP unit and its testbench

SIM := obj_dir/Vtb_pmp_top

.PHONY: all run lint clean

all: run

$(SIM): build.f src/*.sv tb/*.sv
	verilator --binary --timing -f build.f --top-module tb_pmp_top -o Vtb_pmp_top

# Simulation output stays on the terminal, the grep decides the status
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module tb_pmp_top

clean:
	rm -rf obj_dir

//--- build.f
src/pmp_pkg.sv
src/pmp_csr_regs.sv
src/pmp_chan_check.sv
src/pmp_fault_log.sv
src/pmp_top.sv
tb/tb_pmp_top.sv

//--- src/pmp_chan_check.sv
/*
 * Combinational PMP access check for one channel against all regions,
 * OFF/TOR/NA4/NAPOT matching with original and MML permission rules
 */
`timescale 1ns/1ps
`default_nettype none

module pmp_chan_check (
  // Region config from the CSR block
  input  pmp_pkg::pmp_cfg_t              cfg_i      [pmp_pkg::PMP_NUM_REGIONS],
  input  logic [pmp_pkg::PMP_ADDR_W-1:0] addr_i     [pmp_pkg::PMP_NUM_REGIONS],
  input  pmp_pkg::pmp_mseccfg_t          mseccfg_i,
  // Request on this channel
  input  logic [pmp_pkg::PMP_ADDR_W-1:0] req_addr_i,
  input  pmp_pkg::pmp_req_e              req_type_i,
  input  pmp_pkg::priv_lvl_e             priv_i,
  output logic                           fault_o
);

  import pmp_pkg::*;

  // Region bounds and NAPOT masks, word granular
  logic [PMP_ADDR_W-1:0] region_start [PMP_NUM_REGIONS];
  logic [PMP_ADDR_W-1:2] napot_mask   [PMP_NUM_REGIONS];

  // Per region results
  logic [PMP_NUM_REGIONS-1:0] region_match;
  logic [PMP_NUM_REGIONS-1:0] perm_basic;
  logic [PMP_NUM_REGIONS-1:0] perm_orig;
  logic [PMP_NUM_REGIONS-1:0] perm_mml;

  // Request decode
  logic is_exec;
  logic is_write;
  logic is_read;
  logic is_m;
  logic matched;

  assign is_exec  = (req_type_i == PMP_ACC_EXEC);
  assign is_write = (req_type_i == PMP_ACC_WRITE);
  assign is_read  = (req_type_i == PMP_ACC_READ);
  assign is_m     = (priv_i == PRIV_LVL_M);

  for (genvar r = 0; r < PMP_NUM_REGIONS; r++) begin : g_region

    // ----------------------------------------
    // Address matching
    // ----------------------------------------
    // TOR base is zero for entry 0, else the entry below
    if (r == 0) begin : g_base0
      assign region_start[r] = '0;
    end else begin : g_base
      assign region_start[r] = addr_i[r-1];
    end

    // NAPOT size from trailing ones, bit 2 always ignored
    always_comb begin
      logic run;
      run = 1'b1;
      for (int b = 2; b < PMP_ADDR_W; b++) begin
        napot_mask[r][b] = ~run;
        run = run & addr_i[r][b];
      end
    end

    always_comb begin
      case (cfg_i[r].mode)
        PMP_MODE_TOR: begin
          region_match[r] =
              (req_addr_i[PMP_ADDR_W-1:2] >= region_start[r][PMP_ADDR_W-1:2]) &&
              (req_addr_i[PMP_ADDR_W-1:2] <  addr_i[r][PMP_ADDR_W-1:2]);
        end
        PMP_MODE_NA4: begin
          region_match[r] = (req_addr_i[PMP_ADDR_W-1:2] == addr_i[r][PMP_ADDR_W-1:2]);
        end
        PMP_MODE_NAPOT: begin
          region_match[r] =
              ((req_addr_i[PMP_ADDR_W-1:2] & napot_mask[r]) ==
               (addr_i[r][PMP_ADDR_W-1:2] & napot_mask[r]));
        end
        default: region_match[r] = 1'b0;  // OFF
      endcase
    end

    // ----------------------------------------
    // Permissions
    // ----------------------------------------
    assign perm_basic[r] = (is_exec & cfg_i[r].exec) |
                           (is_write & cfg_i[r].write) |
                           (is_read & cfg_i[r].read);

    // Classic rules, unlocked entries never bind M mode
    assign perm_orig[r] = is_m ? (~cfg_i[r].lock | perm_basic[r]) : perm_basic[r];

    // Smepmp rules when MML is set
    always_comb begin
      perm_mml[r] = 1'b0;
      if (!cfg_i[r].read && cfg_i[r].write) begin
        // Shared region encodings, selected by L and X
        case ({cfg_i[r].lock, cfg_i[r].exec})
          2'b00:   perm_mml[r] = is_read | (is_write & is_m);
          2'b01:   perm_mml[r] = is_read | is_write;
          2'b10:   perm_mml[r] = is_exec;
          default: perm_mml[r] = is_exec | (is_read & is_m);
        endcase
      end else if (cfg_i[r].lock & cfg_i[r].exec & cfg_i[r].write & cfg_i[r].read) begin
        // Read only for everyone
        perm_mml[r] = is_read;
      end else if (is_m) begin
        // M needs a locked entry
        perm_mml[r] = cfg_i[r].lock & perm_basic[r];
      end else begin
        // S and U need an unlocked entry
        perm_mml[r] = ~cfg_i[r].lock & perm_basic[r];
      end
    end

  end

  // ----------------------------------------
  // Priority and verdict
  // ----------------------------------------
  always_comb begin
    // No match: deny below M, or everywhere under MMWP
    matched = 1'b0;
    fault_o = mseccfg_i.mmwp | ~is_m;
    // Lowest numbered match decides
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      if (!matched && region_match[r]) begin
        matched = 1'b1;
        fault_o = mseccfg_i.mml ? ~perm_mml[r] : ~perm_orig[r];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/pmp_csr_regs.sv
/*
 * PMP CSR storage: pmpcfg0, pmpaddr0..3 and mseccfg,
 * lock-protected writes, sticky security bits and combinational read-back
 */
`timescale 1ns/1ps
`default_nettype none

module pmp_csr_regs (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // CSR port
  input  logic                          csr_we_i,
  input  logic [11:0]                   csr_addr_i,
  input  logic [31:0]                   csr_wdata_i,
  output logic [31:0]                   csr_rdata_o,
  // Decoded config towards the checkers
  output pmp_pkg::pmp_cfg_t             cfg_o     [pmp_pkg::PMP_NUM_REGIONS],
  output logic [pmp_pkg::PMP_ADDR_W-1:0] addr_o   [pmp_pkg::PMP_NUM_REGIONS],
  output pmp_pkg::pmp_mseccfg_t         mseccfg_o
);

  import pmp_pkg::*;

  // Stored state
  pmp_cfg_t     cfg_q  [PMP_NUM_REGIONS];
  logic [31:0]  addr_q [PMP_NUM_REGIONS];
  pmp_mseccfg_t mseccfg_q;

  // Byte and word views of pmpcfg0
  pmp_cfg_word_u cfg_wr;
  pmp_cfg_word_u cfg_rd;
  pmp_cfg_t      cfg_new [PMP_NUM_REGIONS];

  // Write enables per register
  logic [PMP_NUM_REGIONS-1:0] cfg_we;
  logic [PMP_NUM_REGIONS-1:0] addr_we;
  logic                       mseccfg_we;

  // Entry r is locked and in TOR, one extra top slot stays clear
  logic [PMP_NUM_REGIONS:0]   tor_locked;
  logic                       any_locked;

  // ----------------------------------------
  // Write decode
  // ----------------------------------------
  assign cfg_wr.raw = csr_wdata_i;
  assign mseccfg_we = csr_we_i & (csr_addr_i == CSR_MSECCFG);

  always_comb begin
    any_locked                  = 1'b0;
    tor_locked[PMP_NUM_REGIONS] = 1'b0;
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      any_locked    = any_locked | cfg_q[r].lock;
      tor_locked[r] = cfg_q[r].lock & (cfg_q[r].mode == PMP_MODE_TOR);
    end
  end

  always_comb begin
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      // New byte with reserved bits forced to zero
      cfg_new[r]          = cfg_wr.cfg[r];
      cfg_new[r].reserved = 2'b00;
      // R=0 W=1 is reserved without MML, drop W
      if (!mseccfg_q.mml && !cfg_new[r].read && cfg_new[r].write) begin
        cfg_new[r].write = 1'b0;
      end
      // Locked bytes only open up under RLB
      cfg_we[r] = csr_we_i & (csr_addr_i == CSR_PMPCFG0) &
                  (~cfg_q[r].lock | mseccfg_q.rlb);
      // Address also frozen when the entry above is a locked TOR top
      addr_we[r] = csr_we_i & (csr_addr_i == (CSR_PMPADDR0 + 12'(r))) &
                   (~(cfg_q[r].lock | tor_locked[r+1]) | mseccfg_q.rlb);
    end
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
        cfg_q[r]  <= '0;
        addr_q[r] <= '0;
      end
      mseccfg_q <= '0;
    end else begin
      for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
        if (cfg_we[r]) begin
          cfg_q[r] <= cfg_new[r];
        end
        if (addr_we[r]) begin
          addr_q[r] <= csr_wdata_i;
        end
      end
      if (mseccfg_we) begin
        // MML and MMWP are sticky until reset
        mseccfg_q.mml  <= mseccfg_q.mml | csr_wdata_i[0];
        mseccfg_q.mmwp <= mseccfg_q.mmwp | csr_wdata_i[1];
        // RLB cannot be raised once any entry is locked
        mseccfg_q.rlb  <= csr_wdata_i[2] & (mseccfg_q.rlb | ~any_locked);
      end
    end
  end

  // ----------------------------------------
  // Outputs and read-back
  // ----------------------------------------
  always_comb begin
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      cfg_o[r]     = cfg_q[r];
      // Word address to byte address
      addr_o[r]    = {addr_q[r], 2'b00};
      cfg_rd.cfg[r] = cfg_q[r];
    end
  end

  assign mseccfg_o = mseccfg_q;

  always_comb begin
    // Unmapped CSRs read zero
    csr_rdata_o = '0;
    if (csr_addr_i == CSR_PMPCFG0) begin
      csr_rdata_o = cfg_rd.raw;
    end else if (csr_addr_i == CSR_MSECCFG) begin
      csr_rdata_o = {29'b0, mseccfg_q};
    end
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      if (csr_addr_i == (CSR_PMPADDR0 + 12'(r))) begin
        csr_rdata_o = addr_q[r];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/pmp_fault_log.sv
/*
 * Registered per-channel verdicts, first fault capture with clear,
 * saturating fault counter
 */
`timescale 1ns/1ps
`default_nettype none

module pmp_fault_log (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Requests and raw verdicts
  input  logic                           req_valid_i  [pmp_pkg::PMP_NUM_CHAN],
  input  logic [pmp_pkg::PMP_ADDR_W-1:0] req_addr_i   [pmp_pkg::PMP_NUM_CHAN],
  input  pmp_pkg::pmp_req_e              req_type_i   [pmp_pkg::PMP_NUM_CHAN],
  input  logic                           fault_i      [pmp_pkg::PMP_NUM_CHAN],
  input  logic                           fault_clear_i,
  // Responses, one cycle after the request
  output logic                           rsp_valid_o  [pmp_pkg::PMP_NUM_CHAN],
  output logic                           req_err_o    [pmp_pkg::PMP_NUM_CHAN],
  // First fault record
  output logic                           fault_valid_o,
  output logic [pmp_pkg::PMP_ADDR_W-1:0] fault_addr_o,
  output logic                           fault_chan_o,
  output pmp_pkg::pmp_req_e              fault_type_o,
  output logic [7:0]                     fault_count_o
);

  import pmp_pkg::*;

  logic [PMP_NUM_CHAN-1:0] hit;
  logic [PMP_NUM_CHAN-1:0] rsp_valid_q;
  logic [PMP_NUM_CHAN-1:0] req_err_q;
  logic                    fault_valid_q;
  logic [7:0]              fault_count_q;
  logic [7:0]              hit_cnt;
  logic [8:0]              count_sum;
  logic                    sel_chan;
  logic                    capture;

  // Scan high to low so channel 0 wins a tie
  always_comb begin
    sel_chan = 1'b0;
    hit_cnt  = '0;
    for (int c = PMP_NUM_CHAN - 1; c >= 0; c--) begin
      hit[c] = req_valid_i[c] & fault_i[c];
      if (hit[c]) begin
        sel_chan = 1'(c);
        hit_cnt  = hit_cnt + 8'd1;
      end
    end
  end

  // Capture when empty, or when a clear meets a new fault
  assign capture   = (|hit) & (~fault_valid_q | fault_clear_i);
  assign count_sum = {1'b0, fault_count_q} + {1'b0, hit_cnt};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q   <= '0;
      req_err_q     <= '0;
      fault_valid_q <= 1'b0;
      fault_count_q <= '0;
    end else begin
      for (int c = 0; c < PMP_NUM_CHAN; c++) begin
        rsp_valid_q[c] <= req_valid_i[c];
        req_err_q[c]   <= hit[c];
      end
      if (capture) begin
        fault_valid_q <= 1'b1;
      end else if (fault_clear_i) begin
        fault_valid_q <= 1'b0;
      end
      // Saturate at 255
      fault_count_q <= count_sum[8] ? 8'hFF : count_sum[7:0];
    end
  end

  // Fault record payload
  always_ff @(posedge clk_i) begin
    if (capture) begin
      fault_chan_o <= sel_chan;
      fault_addr_o <= req_addr_i[sel_chan];
      fault_type_o <= req_type_i[sel_chan];
    end
  end

  always_comb begin
    for (int c = 0; c < PMP_NUM_CHAN; c++) begin
      rsp_valid_o[c] = rsp_valid_q[c];
      req_err_o[c]   = req_err_q[c];
    end
  end

  assign fault_valid_o = fault_valid_q;
  assign fault_count_o = fault_count_q;

endmodule

`default_nettype wire

//--- src/pmp_pkg.sv
/*
 * Shared PMP definitions: sizes, CSR numbers, privilege and access enums,
 * region config byte, pmpcfg0 word view and security config
 */
`default_nettype none

package pmp_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int unsigned PMP_NUM_REGIONS = 4;
  // Channel 0 is instruction side, channel 1 is data side
  localparam int unsigned PMP_NUM_CHAN    = 2;
  // Physical address width, pmpaddr holds bits 33:2
  localparam int unsigned PMP_ADDR_W      = 34;

  // ----------------------------------------
  // CSR numbers
  // ----------------------------------------
  localparam logic [11:0] CSR_PMPCFG0  = 12'h3A0;
  // Regions 1..3 follow consecutively
  localparam logic [11:0] CSR_PMPADDR0 = 12'h3B0;
  localparam logic [11:0] CSR_MSECCFG  = 12'h747;

  // Privilege level of the requester
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Access type
  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_READ  = 2'b10
  } pmp_req_e;

  // Address matching mode, the A field of pmpcfg
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // One region config byte, L at bit 7 and R at bit 0
  typedef struct packed {
    logic      lock;
    logic [1:0] reserved;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // pmpcfg0 as a raw word or as four bytes, region 0 in the low byte
  typedef union packed {
    logic [31:0]                     raw;
    pmp_cfg_t [PMP_NUM_REGIONS-1:0] cfg;
  } pmp_cfg_word_u;

  // mseccfg bits 2..0
  typedef struct packed {
    logic rlb;
    logic mmwp;
    logic mml;
  } pmp_mseccfg_t;

endpackage

`default_nettype wire

//--- src/pmp_top.sv
/*
 * PMP top level: CSR block, one checker per channel, fault logger
 */
`timescale 1ns/1ps
`default_nettype none

module pmp_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // CSR access
  input  logic                           csr_we_i,
  input  logic [11:0]                    csr_addr_i,
  input  logic [31:0]                    csr_wdata_i,
  output logic [31:0]                    csr_rdata_o,
  // Access requests, per channel
  input  logic                           req_valid_i   [pmp_pkg::PMP_NUM_CHAN],
  input  logic [pmp_pkg::PMP_ADDR_W-1:0] req_addr_i    [pmp_pkg::PMP_NUM_CHAN],
  input  pmp_pkg::pmp_req_e              req_type_i    [pmp_pkg::PMP_NUM_CHAN],
  input  pmp_pkg::priv_lvl_e             priv_i        [pmp_pkg::PMP_NUM_CHAN],
  input  logic                           fault_clear_i,
  // Verdicts and fault record
  output logic                           rsp_valid_o   [pmp_pkg::PMP_NUM_CHAN],
  output logic                           req_err_o     [pmp_pkg::PMP_NUM_CHAN],
  output logic                           fault_valid_o,
  output logic [pmp_pkg::PMP_ADDR_W-1:0] fault_addr_o,
  output logic                           fault_chan_o,
  output pmp_pkg::pmp_req_e              fault_type_o,
  output logic [7:0]                     fault_count_o
);

  import pmp_pkg::*;

  // Config fan-out to all checkers
  pmp_cfg_t              cfg  [PMP_NUM_REGIONS];
  logic [PMP_ADDR_W-1:0] addr [PMP_NUM_REGIONS];
  pmp_mseccfg_t          mseccfg;
  // Raw verdict per channel
  logic                  fault [PMP_NUM_CHAN];

  pmp_csr_regs i_csr_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .cfg_o       (cfg),
    .addr_o      (addr),
    .mseccfg_o   (mseccfg)
  );

  // ----------------------------------------
  // One checker per channel
  // ----------------------------------------
  for (genvar c = 0; c < PMP_NUM_CHAN; c++) begin : g_chan
    pmp_chan_check i_chan_check (
      .cfg_i      (cfg),
      .addr_i     (addr),
      .mseccfg_i  (mseccfg),
      .req_addr_i (req_addr_i[c]),
      .req_type_i (req_type_i[c]),
      .priv_i     (priv_i[c]),
      .fault_o    (fault[c])
    );
  end

  pmp_fault_log i_fault_log (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_type_i    (req_type_i),
    .fault_i       (fault),
    .fault_clear_i (fault_clear_i),
    .rsp_valid_o   (rsp_valid_o),
    .req_err_o     (req_err_o),
    .fault_valid_o (fault_valid_o),
    .fault_addr_o  (fault_addr_o),
    .fault_chan_o  (fault_chan_o),
    .fault_type_o  (fault_type_o),
    .fault_count_o (fault_count_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_pmp_top.sv
/*
 * Testbench for the PMP top level: clock, reset, LFSR, reference model
 * of matching, permission, lock and fault log rules, directed tests
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pmp_top;

  import pmp_pkg::*;

  localparam int TIMEOUT = 20;

  logic                  clk;
  logic                  rst_n;
  logic                  csr_we;
  logic [11:0]           csr_addr;
  logic [31:0]           csr_wdata;
  logic [31:0]           csr_rdata;
  logic                  req_valid [PMP_NUM_CHAN];
  logic [PMP_ADDR_W-1:0] req_addr  [PMP_NUM_CHAN];
  pmp_req_e              req_type  [PMP_NUM_CHAN];
  priv_lvl_e             priv      [PMP_NUM_CHAN];
  logic                  fault_clear;
  logic                  rsp_valid [PMP_NUM_CHAN];
  logic                  req_err   [PMP_NUM_CHAN];
  logic                  fault_valid;
  logic [PMP_ADDR_W-1:0] fault_addr;
  logic                  fault_chan;
  pmp_req_e              fault_type;
  logic [7:0]            fault_count;

  // Reference copy of the CSR state
  logic [7:0]  m_cfg  [PMP_NUM_REGIONS];
  logic [31:0] m_addr [PMP_NUM_REGIONS];
  logic        m_mml;
  logic        m_mmwp;
  logic        m_rlb;
  // Reference fault record
  logic        m_fv;
  logic [33:0] m_faddr;
  logic        m_fchan;
  pmp_req_e    m_ftype;
  int          m_fcnt;
  logic [15:0] lfsr;

  pmp_top i_pmp_top (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .csr_we_i      (csr_we),
    .csr_addr_i    (csr_addr),
    .csr_wdata_i   (csr_wdata),
    .csr_rdata_o   (csr_rdata),
    .req_valid_i   (req_valid),
    .req_addr_i    (req_addr),
    .req_type_i    (req_type),
    .priv_i        (priv),
    .fault_clear_i (fault_clear),
    .rsp_valid_o   (rsp_valid),
    .req_err_o     (req_err),
    .fault_valid_o (fault_valid),
    .fault_addr_o  (fault_addr),
    .fault_chan_o  (fault_chan),
    .fault_type_o  (fault_type),
    .fault_count_o (fault_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // Random data and reference model
  // ----------------------------------------
  // 16 bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [33:0] rand_bits(input int n);
    logic [33:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v = {v[32:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic pmp_req_e rand_type();
    logic [1:0] v;
    v = 2'(rand_bits(2));
    return (v == 2'b11) ? PMP_ACC_READ : pmp_req_e'(v);
  endfunction

  function automatic priv_lvl_e rand_priv();
    logic [1:0] v;
    v = 2'(rand_bits(2));
    return (v == 2'b10) ? PRIV_LVL_U : priv_lvl_e'(v);
  endfunction

  // Word granular match of region r
  function automatic logic region_hits(input int r, input logic [33:0] a);
    logic [63:0] w;
    logic [63:0] lo;
    logic [63:0] top;
    int          t;
    w   = 64'(a[33:2]);
    top = 64'(m_addr[r]);
    lo  = '0;
    if (r > 0) begin
      lo = 64'(m_addr[r-1]);
    end
    // NAPOT ignores the trailing ones plus one more bit
    t = 0;
    while (t < 32 && m_addr[r][t]) begin
      t++;
    end
    case (m_cfg[r][4:3])
      2'b01:   return (w >= lo) && (w < top);
      2'b10:   return w == top;
      2'b11:   return (w >> (t + 1)) == (top >> (t + 1));
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic expect_fault(input logic [33:0] a, input pmp_req_e ty,
                                        input priv_lvl_e p);
    logic [7:0] c;
    logic       m;
    logic       need;
    logic       ok;
    m = (p == PRIV_LVL_M);
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      if (region_hits(r, a)) begin
        c = m_cfg[r];
        need = (ty == PMP_ACC_EXEC) ? c[2] : (ty == PMP_ACC_WRITE) ? c[1] : c[0];
        if (!m_mml) begin
          ok = (m && !c[7]) || need;
        end else if (!c[0] && c[1]) begin
          // Shared encodings by lock and exec
          case ({c[7], c[2]})
            2'b00:   ok = (ty == PMP_ACC_READ) || (ty == PMP_ACC_WRITE && m);
            2'b01:   ok = (ty != PMP_ACC_EXEC);
            2'b10:   ok = (ty == PMP_ACC_EXEC);
            default: ok = (ty == PMP_ACC_EXEC) || (ty == PMP_ACC_READ && m);
          endcase
        end else if (c[7] && c[2] && c[1] && c[0]) begin
          ok = (ty == PMP_ACC_READ);
        end else begin
          ok = need && (m ? c[7] : !c[7]);
        end
        return !ok;
      end
    end
    return m_mmwp || !m;
  endfunction

  // Lock rules applied to the reference state
  function automatic void shadow_write(input logic [11:0] a, input logic [31:0] d);
    logic       any_l;
    logic       frozen;
    logic [7:0] b;
    any_l = 1'b0;
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      any_l = any_l | m_cfg[r][7];
    end
    if (a == CSR_PMPCFG0) begin
      for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
        if (!m_cfg[r][7] || m_rlb) begin
          b = d[8*r +: 8] & 8'h9F;
          if (!m_mml && !b[0] && b[1]) begin
            b[1] = 1'b0;
          end
          m_cfg[r] = b;
        end
      end
    end else if (a == CSR_MSECCFG) begin
      m_mml  = m_mml | d[0];
      m_mmwp = m_mmwp | d[1];
      m_rlb  = d[2] && (m_rlb || !any_l);
    end
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      frozen = m_cfg[r][7];
      if (r < PMP_NUM_REGIONS - 1) begin
        frozen = frozen || (m_cfg[r+1][7] && m_cfg[r+1][4:3] == 2'b01);
      end
      if (a == CSR_PMPADDR0 + 12'(r) && (m_rlb || !frozen)) begin
        m_addr[r] = d;
      end
    end
  endfunction

  function automatic logic [31:0] shadow_read(input logic [11:0] a);
    logic [31:0] v;
    v = '0;
    if (a == CSR_PMPCFG0) v = {m_cfg[3], m_cfg[2], m_cfg[1], m_cfg[0]};
    if (a == CSR_MSECCFG) v = {29'd0, m_rlb, m_mmwp, m_mml};
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      if (a == CSR_PMPADDR0 + 12'(r)) v = m_addr[r];
    end
    return v;
  endfunction

  // ----------------------------------------
  // Drivers and checks
  // ----------------------------------------
  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp) begin
      $display("ERR %0t: %s, got %0h expected %0h", $time, msg, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic apply_reset();
    rst_n       = 1'b0;
    csr_we      = 1'b0;
    csr_addr    = '0;
    csr_wdata   = '0;
    fault_clear = 1'b0;
    for (int c = 0; c < PMP_NUM_CHAN; c++) begin
      req_valid[c] = 1'b0;
      req_addr[c]  = '0;
      req_type[c]  = PMP_ACC_EXEC;
      priv[c]      = PRIV_LVL_M;
    end
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      m_cfg[r]  = '0;
      m_addr[r] = '0;
    end
    m_mml  = 1'b0;
    m_mmwp = 1'b0;
    m_rlb  = 1'b0;
    m_fv   = 1'b0;
    m_fcnt = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic csr_write(input logic [11:0] a, input logic [31:0] d);
    @(negedge clk);
    csr_we    = 1'b1;
    csr_addr  = a;
    csr_wdata = d;
    shadow_write(a, d);
    @(negedge clk);
    csr_we = 1'b0;
  endtask

  task automatic expect_read(input logic [11:0] a, input string msg);
    @(negedge clk);
    csr_addr = a;
    #1;
    check_eq(csr_rdata, shadow_read(a), msg);
  endtask

  task automatic compare_all_csrs();
    expect_read(CSR_PMPCFG0, "pmpcfg0 read-back");
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      expect_read(CSR_PMPADDR0 + 12'(r), "pmpaddr read-back");
    end
    expect_read(CSR_MSECCFG, "mseccfg read-back");
    expect_read(12'h3A1, "unmapped CSR");
  endtask

  // One request cycle on both channels, then the verdict and fault record
  task automatic run_req(input logic [1:0] v, input logic [33:0] a0, input logic [33:0] a1,
                         input pmp_req_e t0, input pmp_req_e t1,
                         input priv_lvl_e p0, input priv_lvl_e p1, input logic clr);
    logic e0;
    logic e1;
    logic h0;
    logic h1;
    int   cycles;
    @(negedge clk);
    req_valid[0] = v[0];
    req_valid[1] = v[1];
    req_addr[0]  = a0;
    req_addr[1]  = a1;
    req_type[0]  = t0;
    req_type[1]  = t1;
    priv[0]      = p0;
    priv[1]      = p1;
    fault_clear  = clr;
    e0 = expect_fault(a0, t0, p0);
    e1 = expect_fault(a1, t1, p1);
    h0 = v[0] & e0;
    h1 = v[1] & e1;
    // First fault wins, channel 0 on a tie, a clear yields to a new fault
    if ((h0 || h1) && (!m_fv || clr)) begin
      m_fv    = 1'b1;
      m_fchan = !h0;
      m_faddr = h0 ? a0 : a1;
      m_ftype = h0 ? t0 : t1;
    end else if (clr) begin
      m_fv = 1'b0;
    end
    m_fcnt = (m_fcnt + h0 + h1 > 255) ? 255 : m_fcnt + h0 + h1;
    @(negedge clk);
    req_valid[0] = 1'b0;
    req_valid[1] = 1'b0;
    fault_clear  = 1'b0;
    cycles = 1;
    if (v != 2'b00) begin
      while (!rsp_valid[0] && !rsp_valid[1]) begin
        if (cycles >= TIMEOUT) begin
          $display("Timed out waiting for rsp_valid after a request");
          $display("FAIL: see errors above");
          $fatal(1, "no response");
        end
        @(negedge clk);
        cycles++;
      end
      check_eq(cycles, 1, "response latency");
      check_eq(rsp_valid[0], v[0], "rsp_valid ch0");
      check_eq(rsp_valid[1], v[1], "rsp_valid ch1");
      if (v[0]) check_eq(req_err[0], e0, "req_err ch0");
      if (v[1]) check_eq(req_err[1], e1, "req_err ch1");
    end
    check_eq(fault_valid, m_fv, "fault_valid");
    check_eq(fault_count, m_fcnt, "fault_count");
    if (m_fv) begin
      check_eq(fault_chan, m_fchan, "fault_chan");
      check_eq(fault_addr, m_faddr, "fault_addr");
      check_eq(fault_type, m_ftype, "fault_type");
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic reset_defaults();
    apply_reset();
    compare_all_csrs();
    run_req(2'b11, 34'h0_8000_0000, 34'h0_8000_0004, PMP_ACC_READ, PMP_ACC_EXEC,
            PRIV_LVL_M, PRIV_LVL_U, 1'b0);
    check_eq(req_err[0], 1'b0, "M access with no regions");
    check_eq(req_err[1], 1'b1, "U access with no regions");
    // Response is a single cycle pulse
    @(negedge clk);
    check_eq(rsp_valid[0], 1'b0, "rsp_valid pulse width");
    run_req(2'b10, 34'h0, 34'h1_0000_0000, PMP_ACC_EXEC, PMP_ACC_WRITE,
            PRIV_LVL_M, PRIV_LVL_S, 1'b0);
    check_eq(req_err[1], 1'b1, "S access with no regions");
  endtask

  task automatic address_modes();
    int offs [10] = '{'h40, 'h44, 'h3FC, 'h400, 'h43C, 'h440, 'h7FC, 'h800, 'hBFC, 'hC00};
    apply_reset();
    // NA4 at 0x40, NAPOT 0x400..0x43F, TOR 0x800..0xBFF above 0x8000_0000
    csr_write(CSR_PMPADDR0, 32'h2000_0010);
    csr_write(CSR_PMPADDR0 + 12'd1, 32'h2000_0107);
    csr_write(CSR_PMPADDR0 + 12'd2, 32'h2000_0200);
    csr_write(CSR_PMPADDR0 + 12'd3, 32'h2000_0300);
    csr_write(CSR_PMPCFG0, 32'h0B00_1D11);
    compare_all_csrs();
    foreach (offs[k]) begin
      run_req(2'b11, 34'h0_8000_0000 + 34'(offs[k]), 34'h0_8000_0000 + 34'(offs[k]),
              PMP_ACC_READ, PMP_ACC_EXEC, PRIV_LVL_U, PRIV_LVL_U, 1'b0);
    end
    repeat (40) begin
      run_req(2'b11, 34'h0_8000_0000 | rand_bits(12), 34'h0_8000_0000 | rand_bits(12),
              rand_type(), rand_type(), rand_priv(), rand_priv(), 1'b0);
    end
  endtask

  // Locked NAPOT over an NA4, locked exec-only TOR above it
  task automatic lock_setup();
    csr_write(CSR_PMPADDR0, 32'h2000_01FF);
    csr_write(CSR_PMPADDR0 + 12'd1, 32'h2000_0010);
    csr_write(CSR_PMPADDR0 + 12'd2, 32'h2000_0800);
    csr_write(CSR_PMPADDR0 + 12'd3, 32'h2000_0900);
    csr_write(CSR_PMPCFG0, 32'h098C_1799);
  endtask

  task automatic overwrite_all();
    csr_write(CSR_PMPCFG0, 32'h0);
    for (int r = 0; r < PMP_NUM_REGIONS; r++) begin
      csr_write(CSR_PMPADDR0 + 12'(r), 32'h1234_5670 + r);
    end
  endtask

  task automatic priority_and_locks();
    apply_reset();
    lock_setup();
    run_req(2'b11, 34'h0_8000_0040, 34'h0_8000_1000, PMP_ACC_WRITE, PMP_ACC_EXEC,
            PRIV_LVL_M, PRIV_LVL_U, 1'b0);
    check_eq(req_err[0], 1'b1, "lowest region binds M write");
    check_eq(req_err[1], 1'b0, "U exec in TOR region");
    run_req(2'b11, 34'h0_8000_0040, 34'h0_8000_1000, PMP_ACC_READ, PMP_ACC_READ,
            PRIV_LVL_M, PRIV_LVL_U, 1'b0);
    run_req(2'b11, 34'h0_8000_1000, 34'h0_9000_0000, PMP_ACC_WRITE, PMP_ACC_READ,
            PRIV_LVL_M, PRIV_LVL_M, 1'b0);
    // Locked entries and the base of a locked TOR stay put
    overwrite_all();
    csr_write(CSR_MSECCFG, 32'h4);
    compare_all_csrs();
    expect_read(CSR_MSECCFG, "mseccfg after refused rlb");
    check_eq(csr_rdata, 32'h0, "rlb refused while locked");
    // RLB set before locking opens everything up
    apply_reset();
    csr_write(CSR_MSECCFG, 32'h4);
    lock_setup();
    overwrite_all();
    compare_all_csrs();
    lock_setup();
    csr_write(CSR_MSECCFG, 32'h0);
    csr_write(CSR_MSECCFG, 32'h4);
    compare_all_csrs();
  endtask

  task automatic mml_and_mmwp();
    logic [7:0] enc [8] = '{8'h12, 8'h16, 8'h92, 8'h96, 8'h97, 8'h91, 8'h13, 8'h15};
    priv_lvl_e  pr;
    pmp_req_e   ty;
    apply_reset();
    csr_write(CSR_MSECCFG, 32'h4);
    csr_write(CSR_MSECCFG, 32'h5);
    csr_write(CSR_PMPADDR0, 32'h2000_0000);
    foreach (enc[k]) begin
      csr_write(CSR_PMPCFG0, {24'h0, enc[k]});
      expect_read(CSR_PMPCFG0, "MML config byte");
      for (int pi = 0; pi < 3; pi++) begin
        pr = (pi == 2) ? PRIV_LVL_M : priv_lvl_e'(2'(pi));
        for (int ti = 0; ti < 3; ti++) begin
          ty = pmp_req_e'(2'(ti));
          run_req(2'b11, 34'h0_8000_0000, 34'h0_9000_0000, ty, ty, pr, pr, 1'b0);
        end
      end
    end
    // Unmatched M access denied once MMWP is set
    csr_write(CSR_MSECCFG, 32'h2);
    run_req(2'b01, 34'h0_9000_0000, 34'h0, PMP_ACC_READ, PMP_ACC_READ,
            PRIV_LVL_M, PRIV_LVL_M, 1'b0);
    check_eq(req_err[0], 1'b1, "mmwp denies unmatched M");
    csr_write(CSR_MSECCFG, 32'h0);
    expect_read(CSR_MSECCFG, "sticky mml and mmwp");
    check_eq(csr_rdata, 32'h3, "mml and mmwp still set");
  endtask

  task automatic fault_logging();
    apply_reset();
    run_req(2'b10, 34'h0, 34'h0_8000_1230, PMP_ACC_EXEC, PMP_ACC_READ,
            PRIV_LVL_M, PRIV_LVL_U, 1'b0);
    check_eq({fault_chan, fault_count}, {1'b1, 8'd1}, "first fault on ch1");
    // Second fault counted but not captured
    run_req(2'b01, 34'h0_8000_2000, 34'h0, PMP_ACC_WRITE, PMP_ACC_EXEC,
            PRIV_LVL_U, PRIV_LVL_M, 1'b0);
    check_eq(fault_addr, 34'h0_8000_1230, "capture held");
    run_req(2'b00, 34'h0, 34'h0, PMP_ACC_EXEC, PMP_ACC_EXEC, PRIV_LVL_M, PRIV_LVL_M, 1'b1);
    check_eq(fault_valid, 1'b0, "clear");
    run_req(2'b11, 34'h0_0000_3000, 34'h0_0000_4000, PMP_ACC_WRITE, PMP_ACC_EXEC,
            PRIV_LVL_S, PRIV_LVL_U, 1'b0);
    check_eq(fault_chan, 1'b0, "tie goes to ch0");
    // Clear in the same cycle as a new fault
    run_req(2'b10, 34'h0, 34'h2_0000_0008, PMP_ACC_EXEC, PMP_ACC_WRITE,
            PRIV_LVL_M, PRIV_LVL_U, 1'b1);
    check_eq({fault_valid, fault_chan}, 2'b11, "clear with new fault");
    run_req(2'b11, 34'h0_0000_0100, 34'h0_0000_0200, PMP_ACC_READ, PMP_ACC_READ,
            PRIV_LVL_M, PRIV_LVL_M, 1'b0);
    check_eq(fault_count, 8'd5, "fault count");
  endtask

  initial begin
    lfsr = 16'd2411;
    reset_defaults();
    address_modes();
    priority_and_locks();
    mml_and_mmwp();
    fault_logging();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire
